//--- source/mem_miss_config.svh
// ==========================================================================
// Load miss path configuration
// Queue depth and the widths of tags, addresses and assembled responses
// ==========================================================================

`ifndef MEM_MISS_CONFIG_SVH
`define MEM_MISS_CONFIG_SVH

// Pending memory request queue
`define PMRQ_NUM_ENTRIES 8      // Outstanding misses held in order

// Memory request tag
`define TAG_WIDTH 8             // Wraps modulo 256

// Physical address
`define ADDR_WIDTH 40

// Assembled response, two 64-bit beats
`define DATA_WIDTH 128          // SIMD register width

`endif

//--- source/mem_miss_pkg.sv
// ==========================================================================
// Load miss path package
// Width types, load size encoding and the structs passed between blocks
// ==========================================================================

`include "mem_miss_config.svh"

package mem_miss_pkg;

    // Widths with a meaning
    typedef logic [`TAG_WIDTH-1:0]  tag_t;          // Memory request tag
    typedef logic [`ADDR_WIDTH-1:0] addr_t;         // Physical address
    typedef logic [`DATA_WIDTH-1:0] bus_simd_t;     // Replay data, full SIMD width
    typedef logic [63:0]            beat_t;         // One response beat
    typedef logic [63:0]            xreg_t;         // Scalar load result
    typedef logic [4:0]             reg_addr_t;     // Destination register
    typedef logic [$clog2(`PMRQ_NUM_ENTRIES)-1:0] pmrq_ptr_t;  // Queue slot index

    // Access size of the load
    typedef enum logic [2:0] {
        SIZE_B,     // Byte
        SIZE_H,     // Half word
        SIZE_W,     // Word
        SIZE_D,     // Double word
        SIZE_Q      // Quad word, whole SIMD register
    } mem_size_e;

    // Load that missed, as held in the queue
    typedef struct packed {
        logic      valid;
        addr_t     addr;
        reg_addr_t rd;
        mem_size_e size;
        logic      is_signed;  // Sign extend narrow loads
        bus_simd_t imm;        // Filled with replay data
    } miss_instr_t;

    // Request towards memory
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        addr_t addr;
    } mem_req_t;

    // One response beat from memory
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        logic  beat_idx;       // 0 low half, 1 high half
        beat_t data;
    } mem_beat_t;

    // Load result towards the register file
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus_simd_t result;
    } wb_t;

endpackage

//--- source/pending_mem_req_queue.sv
// ==========================================================================
// Pending memory request queue
// Holds outstanding load misses in program order, marks them done when
// their tagged replay returns and presents a finished head for writeback
// ==========================================================================

`timescale 1ns/1ps

`include "mem_miss_config.svh"

module pending_mem_req_queue (
    input  logic                      clk_i,           // Core clock
    input  logic                      rstn_i,          // Async reset, active low

    input  mem_miss_pkg::miss_instr_t instruction_i,   // Miss written at the tail
    input  mem_miss_pkg::tag_t        tag_i,           // Tag given by the issuer

    input  logic                      replay_valid_i,  // Assembled response this cycle
    input  mem_miss_pkg::tag_t        tag_next_i,      // Tag of the returning response
    input  mem_miss_pkg::bus_simd_t   replay_data_i,   // Response data
    input  logic                      flush_i,         // Drop every entry
    input  logic                      advance_head_i,  // Head written back

    output mem_miss_pkg::miss_instr_t finish_instr_o,  // Done head, zero otherwise
    output logic                      full_o           // Early full, stalls the core
);
    import mem_miss_pkg::*;

    // Occupancy counter, one bit wider than the pointers
    typedef logic [$clog2(`PMRQ_NUM_ENTRIES):0] pmrq_cnt_t;

    pmrq_ptr_t head_q;      // Oldest entry
    pmrq_ptr_t tail_q;      // Next free slot
    pmrq_cnt_t num_q;       // Entries held

    logic write_en;
    logic advance_en;

    // Entry storage
    miss_instr_t instr_table [0:`PMRQ_NUM_ENTRIES-1];
    tag_t        tag_table   [0:`PMRQ_NUM_ENTRIES-1];
    logic        done_table  [0:`PMRQ_NUM_ENTRIES-1];   // Replay received

    // Accept while a slot is free
    assign write_en   = instruction_i.valid & (num_q < `PMRQ_NUM_ENTRIES);
    assign advance_en = advance_head_i & (num_q != '0);  // Never pop an empty queue

    always_ff @(posedge clk_i) begin
        // Replay marks every slot holding the tag
        if (replay_valid_i) begin
            for (int j = 0; j < `PMRQ_NUM_ENTRIES; j++) begin
                if (tag_table[j] == tag_next_i) begin
                    done_table[j]      <= 1'b1;
                    instr_table[j].imm <= replay_data_i;   // Data rides in imm
                end
            end
        end

        // A new miss overrides a stale replay hitting the same slot
        if (write_en) begin
            instr_table[tail_q] <= instruction_i;
            tag_table[tail_q]   <= tag_i;
            done_table[tail_q]  <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            tail_q <= '0;
            num_q  <= '0;
        end else if (flush_i) begin
            // Entries left behind are never presented again
            head_q <= '0;
            tail_q <= '0;
            num_q  <= '0;
        end else begin
            head_q <= head_q + pmrq_ptr_t'(advance_en);
            tail_q <= tail_q + pmrq_ptr_t'(write_en);
            num_q  <= num_q + pmrq_cnt_t'(write_en) - pmrq_cnt_t'(advance_en);
        end
    end

    // Head only leaves once its data is back
    assign finish_instr_o = ((num_q != '0) && done_table[head_q]) ?
                            instr_table[head_q] : '0;

    // Rises three slots early for misses already in flight upstream
    assign full_o = (num_q == (`PMRQ_NUM_ENTRIES - 3)) | flush_i | ~rstn_i;

endmodule

//--- source/miss_tag_issuer.sv
// ==========================================================================
// Miss tag issuer
// Tags each entering miss, writes it to the queue and sends the request
// ==========================================================================

`timescale 1ns/1ps

module miss_tag_issuer (
    input  logic                      clk_i,         // Core clock
    input  logic                      rstn_i,        // Async reset, active low

    input  mem_miss_pkg::miss_instr_t miss_instr_i,  // Load that missed
    input  logic                      stall_i,       // Queue early full
    input  logic                      flush_i,       // Drop the pending request

    output mem_miss_pkg::miss_instr_t q_instr_o,     // Queue write, same cycle
    output mem_miss_pkg::tag_t        q_tag_o,       // Tag for the queue entry
    output mem_miss_pkg::mem_req_t    mem_req_o      // Request to memory
);
    import mem_miss_pkg::*;

    tag_t  tag_cnt_q;       // Next tag, survives flush
    logic  req_valid_q;
    tag_t  req_tag_q;
    addr_t req_addr_q;
    logic  issue_valid;

    // Misses arriving under stall are lost
    assign issue_valid = miss_instr_i.valid & ~stall_i;

    always_comb begin
        q_instr_o       = miss_instr_i;
        q_instr_o.valid = issue_valid;
        q_instr_o.imm   = '0;           // Filled later by the replay
    end

    assign q_tag_o = tag_cnt_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tag_cnt_q   <= '0;
            req_valid_q <= 1'b0;
        end else begin
            tag_cnt_q   <= tag_cnt_q + tag_t'(issue_valid);  // Wraps modulo 256
            req_valid_q <= issue_valid & ~flush_i;           // One cycle pulse
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        if (issue_valid) begin
            req_tag_q  <= tag_cnt_q;
            req_addr_q <= miss_instr_i.addr;
        end
    end

    assign mem_req_o.valid = req_valid_q;
    assign mem_req_o.tag   = req_tag_q;
    assign mem_req_o.addr  = req_addr_q;

endmodule

//--- source/replay_collector.sv
// ==========================================================================
// Replay collector
// Pairs the two 64-bit beats of each tag into one 128-bit replay pulse
// ==========================================================================

`timescale 1ns/1ps

`include "mem_miss_config.svh"

module replay_collector (
    input  logic                    clk_i,           // Core clock
    input  logic                    rstn_i,          // Async reset, active low

    input  mem_miss_pkg::mem_beat_t mem_beat_i,      // Beat from memory
    input  logic                    flush_i,         // Drop partial responses

    output logic                    replay_valid_o,  // Assembled word ready
    output mem_miss_pkg::tag_t      replay_tag_o,    // Its tag
    output mem_miss_pkg::bus_simd_t replay_data_o    // Beat 1 high, beat 0 low
);
    import mem_miss_pkg::*;

    // Partial responses waiting for their other beat
    logic [`PMRQ_NUM_ENTRIES-1:0] slot_vld_q;        // First beat present
    tag_t                         slot_tag_q  [0:`PMRQ_NUM_ENTRIES-1];
    beat_t                        slot_beat_q [0:`PMRQ_NUM_ENTRIES-1];

    logic      hit;           // Beat completes a stored tag
    pmrq_ptr_t hit_idx;
    logic      free_found;
    pmrq_ptr_t free_idx;

    logic      replay_valid_q;
    tag_t      replay_tag_q;
    bus_simd_t replay_data_q;

    // Lookup, lowest slot wins
    always_comb begin
        hit        = 1'b0;
        hit_idx    = '0;
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = `PMRQ_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (slot_vld_q[i] && (slot_tag_q[i] == mem_beat_i.tag)) begin
                hit     = 1'b1;
                hit_idx = pmrq_ptr_t'(i);
            end
            if (!slot_vld_q[i]) begin
                free_found = 1'b1;
                free_idx   = pmrq_ptr_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            slot_vld_q     <= '0;
            replay_valid_q <= 1'b0;
        end else if (flush_i) begin
            slot_vld_q     <= '0;       // Late beats start over as new partials
            replay_valid_q <= 1'b0;
        end else begin
            replay_valid_q <= mem_beat_i.valid & hit;
            if (mem_beat_i.valid) begin
                if (hit) begin
                    slot_vld_q[hit_idx] <= 1'b0;        // Pair complete
                end else if (free_found) begin
                    slot_vld_q[free_idx] <= 1'b1;       // Park first beat
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_beat_i.valid && !hit) begin
            slot_tag_q[free_idx]  <= mem_beat_i.tag;
            slot_beat_q[free_idx] <= mem_beat_i.data;
        end
        if (mem_beat_i.valid && hit) begin
            replay_tag_q  <= mem_beat_i.tag;
            replay_data_q <= mem_beat_i.beat_idx ?
                             {mem_beat_i.data, slot_beat_q[hit_idx]} :
                             {slot_beat_q[hit_idx], mem_beat_i.data};
        end
    end

    assign replay_valid_o = replay_valid_q;
    assign replay_tag_o   = replay_tag_q;
    assign replay_data_o  = replay_data_q;

endmodule

//--- source/mem_writeback_port.sv
// ==========================================================================
// Memory writeback port
// Pops the finished queue head and formats the load result by size
// ==========================================================================

`timescale 1ns/1ps

module mem_writeback_port (
    input  logic                      clk_i,           // Core clock
    input  logic                      rstn_i,          // Async reset, active low

    input  mem_miss_pkg::miss_instr_t finish_instr_i,  // Done head from the queue
    input  logic                      wb_stall_i,      // Register file busy
    input  logic                      flush_i,         // Nothing leaves on flush

    output logic                      advance_head_o,  // Pop the head
    output mem_miss_pkg::wb_t         wb_o             // Formatted result
);
    import mem_miss_pkg::*;

    xreg_t     scalar;          // Narrow loads, extended to 64 bits
    bus_simd_t result;
    bus_simd_t data;

    logic      wb_valid_q;
    reg_addr_t wb_rd_q;
    bus_simd_t wb_result_q;

    assign data = finish_instr_i.imm;

    // Head is valid only once done
    assign advance_head_o = finish_instr_i.valid & ~wb_stall_i & ~flush_i;

    always_comb begin
        case (finish_instr_i.size)
            SIZE_B:  scalar = finish_instr_i.is_signed ? {{56{data[7]}}, data[7:0]} :
                                                         {56'b0, data[7:0]};
            SIZE_H:  scalar = finish_instr_i.is_signed ? {{48{data[15]}}, data[15:0]} :
                                                         {48'b0, data[15:0]};
            SIZE_W:  scalar = finish_instr_i.is_signed ? {{32{data[31]}}, data[31:0]} :
                                                         {32'b0, data[31:0]};
            default: scalar = data[63:0];   // Double word, no extension
        endcase

        // Quad loads keep the whole register
        if (finish_instr_i.size == SIZE_Q) begin
            result = data;
        end else begin
            result = {64'b0, scalar};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= advance_head_o;   // One cycle per pop
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (advance_head_o) begin
            wb_rd_q     <= finish_instr_i.rd;
            wb_result_q <= result;
        end
    end

    assign wb_o.valid  = wb_valid_q;
    assign wb_o.rd     = wb_rd_q;
    assign wb_o.result = wb_result_q;

endmodule

//--- source/mem_miss_top.sv
// ==========================================================================
// Load miss path top
// Issuer, pending request queue, response collector and writeback port
// ==========================================================================

`timescale 1ns/1ps

module mem_miss_top (
    input  logic                      clk_i,         // Core clock
    input  logic                      rstn_i,        // Async reset, active low

    input  mem_miss_pkg::miss_instr_t miss_instr_i,  // Load that missed the cache
    input  logic                      flush_i,       // Pipeline flush
    input  logic                      wb_stall_i,    // Writeback held off
    input  mem_miss_pkg::mem_beat_t   mem_beat_i,    // Response beats

    output logic                      stall_o,       // Early full to the core
    output mem_miss_pkg::mem_req_t    mem_req_o,     // Request to memory
    output mem_miss_pkg::wb_t         wb_o           // Load result
);
    import mem_miss_pkg::*;

    // Issuer to queue
    miss_instr_t q_instr;
    tag_t        q_tag;
    logic        full;

    // Collector to queue
    logic        replay_valid;
    tag_t        replay_tag;
    bus_simd_t   replay_data;

    // Queue and writeback port
    miss_instr_t finish_instr;
    logic        advance_head;

    assign stall_o = full;

    miss_tag_issuer i_miss_tag_issuer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .miss_instr_i (miss_instr_i),
        .stall_i      (full),
        .flush_i      (flush_i),
        .q_instr_o    (q_instr),
        .q_tag_o      (q_tag),
        .mem_req_o    (mem_req_o)
    );

    pending_mem_req_queue i_pending_mem_req_queue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instruction_i  (q_instr),
        .tag_i          (q_tag),
        .replay_valid_i (replay_valid),
        .tag_next_i     (replay_tag),
        .replay_data_i  (replay_data),
        .flush_i        (flush_i),
        .advance_head_i (advance_head),
        .finish_instr_o (finish_instr),
        .full_o         (full)
    );

    replay_collector i_replay_collector (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .mem_beat_i     (mem_beat_i),
        .flush_i        (flush_i),
        .replay_valid_o (replay_valid),
        .replay_tag_o   (replay_tag),
        .replay_data_o  (replay_data)
    );

    mem_writeback_port i_mem_writeback_port (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .finish_instr_i (finish_instr),
        .wb_stall_i     (wb_stall_i),
        .flush_i        (flush_i),
        .advance_head_o (advance_head),
        .wb_o           (wb_o)
    );

endmodule

//--- test/tb_mem_responder.sv
// ==========================================================================
// Behavioral memory for the load miss testbench
// Returns both beats of every request later, in random tag and beat order
// ==========================================================================

`timescale 1ns/1ps

module tb_mem_responder (
    input  logic                    clk_i,   // Testbench clock
    input  logic                    rstn_i,  // Async reset, active low
    input  mem_miss_pkg::mem_req_t  req_i,   // Requests from the DUT
    output mem_miss_pkg::mem_beat_t beat_o   // Response beats
);
    import mem_miss_pkg::*;

    mem_beat_t owed_q [$];      // Beats not yet returned

    // Beat contents mixed from the address, beat 1 differs from beat 0
    function automatic beat_t beat_data(addr_t addr, logic idx);
        beat_t mixed;
        mixed = beat_t'(addr) * 64'h9e37_79b9_7f4a_7c15;
        return idx ? ~{mixed[31:0], mixed[63:32]} : mixed;
    endfunction

    initial beat_o = '0;

    // Requests taken mid cycle
    always @(negedge clk_i) begin : capture
        mem_beat_t b;
        if (rstn_i && req_i.valid) begin
            b.valid = 1'b1;
            b.tag   = req_i.tag;
            for (int i = 0; i < 2; i++) begin
                b.beat_idx = i[0];
                b.data     = beat_data(req_i.addr, i[0]);
                owed_q.push_back(b);
            end
        end
    end

    // Any owed beat may go next, gaps at random
    always @(posedge clk_i or negedge rstn_i) begin : respond
        int unsigned pick;
        if (!rstn_i) begin
            owed_q.delete();
            beat_o <= '0;
        end else if (owed_q.size() != 0 && ($urandom % 3) != 0) begin
            pick = $urandom % owed_q.size();
            beat_o <= owed_q[pick];
            owed_q.delete(pick);
        end else begin
            beat_o <= '0;
        end
    end

endmodule

//--- test/tb_mem_miss_top.sv
// ==========================================================================
// Load miss path testbench
// Out of order memory and in-order writeback checked against a model
// ==========================================================================

`timescale 1ns/1ps

`include "mem_miss_config.svh"

module tb_mem_miss_top;
    import mem_miss_pkg::*;

    logic        clk = 1'b0;
    logic        rstn;
    miss_instr_t miss_instr;
    logic        flush;
    logic        wb_stall;
    mem_beat_t   mem_beat;          // From the responder
    logic        stall;
    mem_req_t    mem_req;
    wb_t         wb;

    miss_instr_t wb_exp_q [$];      // Accepted misses in issue order
    mem_req_t    req_exp_q [$];     // Requests not yet seen
    tag_t        next_tag;          // Kept across flush
    int          occ;               // Entries the queue should hold
    logic        flush_prev;
    logic        wb_stall_prev;

    always #50 clk = ~clk;

    mem_miss_top i_mem_miss_top (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .miss_instr_i (miss_instr),
        .flush_i      (flush),
        .wb_stall_i   (wb_stall),
        .mem_beat_i   (mem_beat),
        .stall_o      (stall),
        .mem_req_o    (mem_req),
        .wb_o         (wb)
    );

    tb_mem_responder i_mem_responder (
        .clk_i  (clk),
        .rstn_i (rstn),
        .req_i  (mem_req),
        .beat_o (mem_beat)
    );

    task automatic stop_failed(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_wb(wb_t got, wb_t exp);
        if (got !== exp)
            stop_failed($sformatf("ERR wb_o got %h expected %h", got, exp));
    endtask

    task automatic check_req(mem_req_t got, mem_req_t exp);
        if (got !== exp)
            stop_failed($sformatf("ERR mem_req_o got %h expected %h", got, exp));
    endtask

    task automatic check_stall(logic got, logic exp);
        if (got !== exp)
            stop_failed($sformatf("ERR stall_o got %h expected %h", got, exp));
    endtask

    // Load result as the register file should see it
    function automatic wb_t expected_wb(miss_instr_t m);
        bus_simd_t resp;
        xreg_t     mask;
        xreg_t     val;
        int        width;
        wb_t       w;
        resp = {i_mem_responder.beat_data(m.addr, 1'b1),
                i_mem_responder.beat_data(m.addr, 1'b0)};
        case (m.size)
            SIZE_B:  width = 8;
            SIZE_H:  width = 16;
            SIZE_W:  width = 32;
            default: width = 64;
        endcase
        mask = (width == 64) ? '1 : ((64'd1 << width) - 64'd1);
        val  = resp[63:0] & mask;
        if (m.is_signed && val[width-1])
            val = val | ~mask;      // Sign extension
        w.valid  = 1'b1;
        w.rd     = m.rd;
        w.result = (m.size == SIZE_Q) ? resp : {64'd0, val};
        return w;
    endfunction

    // One miss at a random address while stall_o is low
    task automatic issue_miss(reg_addr_t rd, mem_size_e size, logic sgn);
        miss_instr_t m;
        mem_req_t    r;
        int          cycles;
        m           = '0;
        m.valid     = 1'b1;
        m.addr      = addr_t'({$urandom, $urandom});
        m.rd        = rd;
        m.size      = size;
        m.is_signed = sgn;
        r.valid     = 1'b1;
        r.tag       = next_tag;
        r.addr      = m.addr;
        cycles      = 0;
        @(negedge clk);
        while (stall) begin
            cycles++;
            if (cycles > 500)
                stop_failed("Timeout, stall_o stayed high and no miss could issue");
            @(negedge clk);
        end
        @(posedge clk);
        miss_instr <= m;
        @(posedge clk);
        miss_instr <= '0;           // Written into the queue at this edge
        wb_exp_q.push_back(m);
        req_exp_q.push_back(r);
        next_tag++;                 // Wraps with the issuer
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (wb_exp_q.size() != 0) begin
            cycles++;
            if (cycles > 2000)
                stop_failed("Timeout, pending loads never wrote back");
            @(posedge clk);
        end
    endtask

    // Requests, writebacks and stall_o against the model
    always @(negedge clk) begin : compare
        if (!rstn) begin
            occ           = 0;
            flush_prev    = 1'b0;
            wb_stall_prev = 1'b0;
            check_stall(stall, 1'b1);   // Queue reports full under reset
        end else begin
            if (mem_req.valid) begin
                if (req_exp_q.size() == 0)
                    stop_failed("Memory request seen with no miss issued");
                else
                    check_req(mem_req, req_exp_q.pop_front());
                occ++;
            end
            if (wb.valid) begin
                if (wb_stall_prev || wb_exp_q.size() == 0)
                    stop_failed("Writeback under wb_stall_i or with no pending miss");
                else
                    check_wb(wb, expected_wb(wb_exp_q.pop_front()));
                occ--;
            end
            if (flush_prev)
                occ = 0;            // Queue emptied at the last edge
            if (flush)
                wb_exp_q.delete();  // Older misses never write back
            check_stall(stall, flush || (occ == `PMRQ_NUM_ENTRIES - 3));
            flush_prev    = flush;
            wb_stall_prev = wb_stall;
        end
    end

    initial begin : stimulus
        int unsigned seed_ret;
        seed_ret   = $urandom(32'hd3e8bbf1);
        rstn       = 1'b0;
        miss_instr = '0;
        flush      = 1'b0;
        wb_stall   = 1'b0;
        next_tag   = '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        // Every size unsigned then signed
        for (int s = 0; s < 5; s++) begin
            issue_miss(reg_addr_t'(2 * s), mem_size_e'(s), 1'b0);
            issue_miss(reg_addr_t'(2 * s + 1), mem_size_e'(s), 1'b1);
        end
        wait_drained();

        // Random traffic
        for (int n = 0; n < 60; n++)
            issue_miss(reg_addr_t'($urandom), mem_size_e'($urandom % 5), 1'($urandom));
        wait_drained();

        // Fill to early full with writeback held
        wb_stall <= 1'b1;
        for (int n = 0; n < `PMRQ_NUM_ENTRIES - 3; n++)
            issue_miss(reg_addr_t'(n + 8), SIZE_W, 1'b1);
        @(negedge clk);
        if (!stall)
            stop_failed("stall_o did not rise at early full");
        repeat (40) @(posedge clk);     // Responses land while nothing may leave
        wb_stall <= 1'b0;
        for (int n = 0; n < 5; n++)
            issue_miss(reg_addr_t'(n + 20), SIZE_B, 1'($urandom));
        wait_drained();

        // Flush with misses outstanding and late responses ignored
        wb_stall <= 1'b1;
        for (int n = 0; n < 3; n++)
            issue_miss(reg_addr_t'(n + 16), SIZE_D, 1'b0);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush    <= 1'b0;
        wb_stall <= 1'b0;
        for (int n = 0; n < 2; n++)
            issue_miss(reg_addr_t'(n + 24), SIZE_H, 1'b1);
        wait_drained();
        repeat (20) @(posedge clk);     // Room for stray writebacks
        if (req_exp_q.size() != 0) begin
            stop_failed("Issued misses never sent a memory request");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+source
source/mem_miss_pkg.sv
source/pending_mem_req_queue.sv
source/miss_tag_issuer.sv
source/replay_collector.sv
source/mem_writeback_port.sv
source/mem_miss_top.sv
test/tb_mem_responder.sv
test/tb_mem_miss_top.sv
